//--- Makefile
VERILATOR ?= verilator
TOP       ?= pipe_cpu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/alu.sv
hw/hazard_unit.sv
hw/pipe_cpu.sv
tb/pipe_cpu_assert.sv
tb/pipe_cpu_tb.sv

//--- hw/alu.sv
// Combinational ALU for add, sub, and, or, sll and sra
// Branch flags always come from a - b, whatever op is selected
`timescale 1ns/10ps
`include "cpu_defs.svh"

module alu (
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    input  isa_pkg::alu_op_e   op,
    input  logic [`REG_AW-1:0] shamt,
    output logic [`XLEN-1:0]   result,
    output logic               not_equal,
    output logic               less_than
);
    import isa_pkg::*;

    logic [`XLEN-1:0] diff;
    logic             ovf;

    assign diff = a - b;
    // Signed overflow of the subtract
    assign ovf = (a[`XLEN-1] ^ b[`XLEN-1]) & (diff[`XLEN-1] ^ a[`XLEN-1]);

    assign not_equal = |diff;
    // Sign of the true difference
    assign less_than = diff[`XLEN-1] ^ ovf;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLL: result = a << shamt;
            ALU_SRA: result = $signed(a) >>> shamt;
            default: result = '0;
        endcase
    end

endmodule

//--- hw/cpu_defs.svh
// Shared widths and instruction field positions of the core
// PC and memory addresses count 32-bit words, not bytes
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define XLEN      32
`define REG_AW    5
`define NUM_REGS  32

// Instruction fields
`define OPC_HI    31
`define OPC_LO    27
`define RD_HI     26
`define RD_LO     22
`define RS_HI     21
`define RS_LO     17
`define RT_HI     16
`define RT_LO     12
`define SHAMT_HI  11
`define SHAMT_LO  7
`define ALUOP_HI  6
`define ALUOP_LO  2
`define IMM_HI    16
`define IMM_LO    0
`define TGT_HI    26
`define TGT_LO    0

`define RESET_PC  32'h0000_0000

`endif

//--- hw/decode_unit.sv
// Combinational instruction decoder for the kept instruction subset
// Unknown opcodes leave all control bits low
`timescale 1ns/10ps
`include "cpu_defs.svh"

module decode_unit (
    input  logic [`XLEN-1:0]   instr,
    output isa_pkg::opcode_e   opcode,
    output logic [`REG_AW-1:0] src_a,
    output logic [`REG_AW-1:0] src_b,
    output logic [`REG_AW-1:0] dest,
    output logic               reg_write,
    output logic               mem_read,
    output logic               mem_write,
    output logic               is_branch,
    output logic               is_jump,
    output logic               use_imm,
    output isa_pkg::alu_op_e   alu_op,
    output logic [`REG_AW-1:0] shamt,
    output logic [`XLEN-1:0]   imm,
    output logic [`XLEN-1:0]   target
);
    import isa_pkg::*;

    logic [`REG_AW-1:0] rd_f;
    logic [`REG_AW-1:0] rs_f;
    logic [`REG_AW-1:0] rt_f;

    assign rd_f = instr[`RD_HI:`RD_LO];
    assign rs_f = instr[`RS_HI:`RS_LO];
    assign rt_f = instr[`RT_HI:`RT_LO];

    assign opcode = opcode_e'(instr[`OPC_HI:`OPC_LO]);
    assign dest   = rd_f;
    assign shamt  = instr[`SHAMT_HI:`SHAMT_LO];

    // 17-bit immediate is sign extended
    assign imm = {{(`XLEN-`IMM_HI-1){instr[`IMM_HI]}}, instr[`IMM_HI:`IMM_LO]};
    // Jump target is zero extended
    assign target = {{(`XLEN-`TGT_HI-1){1'b0}}, instr[`TGT_HI:`TGT_LO]};

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        use_imm   = 1'b0;
        alu_op    = ALU_ADD;
        src_a     = rs_f;
        src_b     = rt_f;
        case (opcode)
            OP_ALU: begin
                reg_write = 1'b1;
                alu_op    = alu_op_e'(instr[`ALUOP_HI:`ALUOP_LO]);
            end
            OP_ADDI: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
            OP_LW: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                use_imm   = 1'b1;
            end
            OP_SW: begin
                // Store data comes from rd on port b
                mem_write = 1'b1;
                use_imm   = 1'b1;
                src_b     = rd_f;
            end
            OP_BNE, OP_BLT: begin
                // Compare rd against rs through a subtract
                is_branch = 1'b1;
                alu_op    = ALU_SUB;
                src_a     = rd_f;
                src_b     = rs_f;
            end
            OP_J: begin
                is_jump = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/hazard_unit.sv
// Forwarding selects, load-use stall and redirect flush
// After the one-cycle load-use stall the load result comes from the memory stage
`timescale 1ns/10ps
`include "cpu_defs.svh"

module hazard_unit (
    input  logic [`REG_AW-1:0] dec_src_a,
    input  logic [`REG_AW-1:0] dec_src_b,
    input  logic               dec_uses_b,
    input  logic [`REG_AW-1:0] ex_src_a,
    input  logic [`REG_AW-1:0] ex_src_b,
    input  logic [`REG_AW-1:0] ex_dest,
    input  logic               ex_mem_read,
    input  logic [`REG_AW-1:0] mem_dest,
    input  logic               mem_reg_write,
    input  logic [`REG_AW-1:0] wb_dest,
    input  logic               wb_reg_write,
    input  logic               redirect,
    output pipe_pkg::fwd_sel_e fwd_a,
    output pipe_pkg::fwd_sel_e fwd_b,
    output logic               stall,
    output logic               flush
);
    import pipe_pkg::*;

    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;
    logic load_use;

    // Register 0 is never a forwarding source
    assign mem_hit_a = mem_reg_write && mem_dest != '0 && mem_dest == ex_src_a;
    assign mem_hit_b = mem_reg_write && mem_dest != '0 && mem_dest == ex_src_b;
    assign wb_hit_a  = wb_reg_write && wb_dest != '0 && wb_dest == ex_src_a;
    assign wb_hit_b  = wb_reg_write && wb_dest != '0 && wb_dest == ex_src_b;

    // Younger result in memory wins over writeback
    assign fwd_a = mem_hit_a ? FWD_MEM : (wb_hit_a ? FWD_WB : FWD_REG);
    assign fwd_b = mem_hit_b ? FWD_MEM : (wb_hit_b ? FWD_WB : FWD_REG);

    // Load in execute feeding the instruction in decode
    assign load_use = ex_mem_read && ex_dest != '0 &&
                      (ex_dest == dec_src_a || (dec_uses_b && ex_dest == dec_src_b));

    // A redirect kills the stalled instruction anyway
    assign flush = redirect;
    assign stall = load_use && !redirect;

endmodule

//--- hw/isa_pkg.sv
// Opcode and ALU function encodings of the instruction set
// Only the kept subset is listed; other opcodes decode as no-ops
package isa_pkg;

    // Primary opcode in bits 31:27
    typedef enum logic [4:0] {
        OP_ALU  = 5'b00000,
        OP_J    = 5'b00001,
        OP_BNE  = 5'b00010,
        OP_ADDI = 5'b00101,
        OP_BLT  = 5'b00110,
        OP_SW   = 5'b00111,
        OP_LW   = 5'b01000
    } opcode_e;

    // ALU function in bits 6:2 of R-type instructions
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

endpackage

//--- hw/pipe_cpu.sv
// Five-stage pipelined core, fetch/decode/execute/memory/writeback
// Instruction and data memories are external and answer in the same cycle
// Branches and jumps resolve in execute and cost two bubbles when taken
`timescale 1ns/10ps
`include "cpu_defs.svh"

module pipe_cpu (
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_data,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    output logic             dmem_we,
    input  logic [`XLEN-1:0] dmem_rdata
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // Fetch
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] fd_instr;
    logic [`XLEN-1:0] fd_pc;

    // Decode outputs
    opcode_e            dec_opcode;
    logic [`REG_AW-1:0] dec_src_a, dec_src_b, dec_dest, dec_shamt;
    logic               dec_reg_write, dec_mem_read, dec_mem_write;
    logic               dec_is_branch, dec_is_jump, dec_use_imm, dec_uses_b;
    alu_op_e            dec_alu_op;
    logic [`XLEN-1:0]   dec_imm, dec_target, rf_a, rf_b;

    // D/X register
    logic               dx_reg_write, dx_mem_read, dx_mem_write, dx_is_branch, dx_is_jump;
    opcode_e            dx_opcode;
    alu_op_e            dx_alu_op;
    logic               dx_use_imm;
    logic [`REG_AW-1:0] dx_src_a, dx_src_b, dx_dest, dx_shamt;
    logic [`XLEN-1:0]   dx_pc, dx_a, dx_b, dx_imm, dx_target;

    // Execute
    fwd_sel_e         fwd_a, fwd_b;
    logic [`XLEN-1:0] op_a, op_b, alu_b, alu_result, ex_target, mem_fwd;
    logic             not_equal, less_than, redirect, stall, flush;

    // X/M and M/W registers
    logic               xm_reg_write, xm_mem_read, xm_mem_write;
    logic [`REG_AW-1:0] xm_dest;
    logic [`XLEN-1:0]   xm_result, xm_store;
    logic               wb_reg_write, wb_mem_read;
    logic [`REG_AW-1:0] wb_dest;
    logic [`XLEN-1:0]   wb_result, wb_load, wb_data;

    assign imem_addr = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RESET_PC;
        end else if (redirect) begin
            pc_q <= ex_target;
        end else if (!stall) begin
            pc_q <= pc_q + 1;
        end
    end

    // All-zero word decodes as add r0, r0, r0 and serves as the F/D bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fd_instr <= '0;
        end else if (flush) begin
            fd_instr <= '0;
        end else if (!stall) begin
            fd_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fd_pc <= pc_q;
        end
    end

    decode_unit decode_unit_inst (
        .instr     (fd_instr),
        .opcode    (dec_opcode),
        .src_a     (dec_src_a),
        .src_b     (dec_src_b),
        .dest      (dec_dest),
        .reg_write (dec_reg_write),
        .mem_read  (dec_mem_read),
        .mem_write (dec_mem_write),
        .is_branch (dec_is_branch),
        .is_jump   (dec_is_jump),
        .use_imm   (dec_use_imm),
        .alu_op    (dec_alu_op),
        .shamt     (dec_shamt),
        .imm       (dec_imm),
        .target    (dec_target)
    );

    // Port b carries a real operand for R-type, branches and store data
    assign dec_uses_b = (dec_opcode == OP_ALU) || dec_is_branch || dec_mem_write;

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (dec_src_a),
        .raddr_b (dec_src_b),
        .we      (wb_reg_write),
        .waddr   (wb_dest),
        .wdata   (wb_data),
        .rdata_a (rf_a),
        .rdata_b (rf_b)
    );

    // Bubble into execute on flush or load-use stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dx_reg_write <= 1'b0;
            dx_mem_read  <= 1'b0;
            dx_mem_write <= 1'b0;
            dx_is_branch <= 1'b0;
            dx_is_jump   <= 1'b0;
        end else if (flush || stall) begin
            dx_reg_write <= 1'b0;
            dx_mem_read  <= 1'b0;
            dx_mem_write <= 1'b0;
            dx_is_branch <= 1'b0;
            dx_is_jump   <= 1'b0;
        end else begin
            dx_reg_write <= dec_reg_write;
            dx_mem_read  <= dec_mem_read;
            dx_mem_write <= dec_mem_write;
            dx_is_branch <= dec_is_branch;
            dx_is_jump   <= dec_is_jump;
        end
    end

    always_ff @(posedge clk) begin
        dx_opcode  <= dec_opcode;
        dx_alu_op  <= dec_alu_op;
        dx_use_imm <= dec_use_imm;
        dx_src_a   <= dec_src_a;
        dx_src_b   <= dec_src_b;
        dx_dest    <= dec_dest;
        dx_shamt   <= dec_shamt;
        dx_pc      <= fd_pc;
        dx_a       <= rf_a;
        dx_b       <= rf_b;
        dx_imm     <= dec_imm;
        dx_target  <= dec_target;
    end

    hazard_unit hazard_unit_inst (
        .dec_src_a     (dec_src_a),
        .dec_src_b     (dec_src_b),
        .dec_uses_b    (dec_uses_b),
        .ex_src_a      (dx_src_a),
        .ex_src_b      (dx_src_b),
        .ex_dest       (dx_dest),
        .ex_mem_read   (dx_mem_read),
        .mem_dest      (xm_dest),
        .mem_reg_write (xm_reg_write),
        .wb_dest       (wb_dest),
        .wb_reg_write  (wb_reg_write),
        .redirect      (redirect),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall),
        .flush         (flush)
    );

    // Load in the memory stage bypasses its read data
    assign mem_fwd = xm_mem_read ? dmem_rdata : xm_result;

    // Operand bypass muxes
    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = mem_fwd;
            FWD_WB:  op_a = wb_data;
            default: op_a = dx_a;
        endcase
        case (fwd_b)
            FWD_MEM: op_b = mem_fwd;
            FWD_WB:  op_b = wb_data;
            default: op_b = dx_b;
        endcase
    end

    assign alu_b = dx_use_imm ? dx_imm : op_b;

    alu alu_inst (
        .a         (op_a),
        .b         (alu_b),
        .op        (dx_alu_op),
        .shamt     (dx_shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // blt and bne share the subtract flags
    assign redirect = dx_is_jump ||
                      (dx_is_branch && ((dx_opcode == OP_BLT) ? less_than : not_equal));
    assign ex_target = dx_is_jump ? dx_target : dx_pc + dx_imm + 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xm_reg_write <= 1'b0;
            xm_mem_read  <= 1'b0;
            xm_mem_write <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_mem_read  <= 1'b0;
        end else begin
            xm_reg_write <= dx_reg_write;
            xm_mem_read  <= dx_mem_read;
            xm_mem_write <= dx_mem_write;
            wb_reg_write <= xm_reg_write;
            wb_mem_read  <= xm_mem_read;
        end
    end

    always_ff @(posedge clk) begin
        xm_dest   <= dx_dest;
        xm_result <= alu_result;
        xm_store  <= op_b;
        wb_dest   <= xm_dest;
        wb_result <= xm_result;
        wb_load   <= dmem_rdata;
    end

    // Memory stage drives the data port directly
    assign dmem_addr  = xm_result;
    assign dmem_wdata = xm_store;
    assign dmem_we    = xm_mem_write;

    assign wb_data = wb_mem_read ? wb_load : wb_result;

endmodule

//--- hw/pipe_pkg.sv
// Pipeline control types shared by the hazard unit and the core
package pipe_pkg;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

endpackage

//--- hw/reg_file.sv
// 32 x 32 register file, two async reads and one write on rising clk
// Register 0 reads zero; a read of the register being written sees new data
`timescale 1ns/10ps
`include "cpu_defs.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`REG_AW-1:0] raddr_a,
    input  logic [`REG_AW-1:0] raddr_b,
    input  logic              we,
    input  logic [`REG_AW-1:0] waddr,
    input  logic [`XLEN-1:0]   wdata,
    output logic [`XLEN-1:0]   rdata_a,
    output logic [`XLEN-1:0]   rdata_b
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through covers the writeback to decode path
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

//--- tb/pipe_cpu_assert.sv
// Concurrent checks on the hazard unit outputs, bound into hazard_unit
// Clock and reset come from the testbench top through the bind connection
`timescale 1ns/10ps
`include "cpu_defs.svh"

module pipe_cpu_assert (
    input logic               clk,
    input logic               rst_n,
    input pipe_pkg::fwd_sel_e fwd_a,
    input pipe_pkg::fwd_sel_e fwd_b,
    input logic               stall,
    input logic               flush,
    input logic [`REG_AW-1:0] mem_dest,
    input logic [`REG_AW-1:0] wb_dest
);
    import pipe_pkg::*;

    // Pipeline control must stay known once out of reset
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown({stall, flush}))
        else $error("hazard unit stall or flush is unknown");

    // Memory-stage bypass needs a real destination register
    assert property (@(posedge clk) disable iff (!rst_n)
        (fwd_a == FWD_MEM || fwd_b == FWD_MEM) |-> mem_dest != '0)
        else $error("forward from memory stage with destination r0");

    // Same for the writeback bypass
    assert property (@(posedge clk) disable iff (!rst_n)
        (fwd_a == FWD_WB || fwd_b == FWD_WB) |-> wb_dest != '0)
        else $error("forward from writeback stage with destination r0");

endmodule

//--- tb/pipe_cpu_tb.sv
// Directed tests for the pipelined core with behavioral memories
// Both memories hold 256 words and wrap on the low 8 address bits
// Programs end in a jump to itself, so the store trace stops there
`timescale 1ns/10ps
`include "cpu_defs.svh"

module pipe_cpu_tb;
    import isa_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int WAIT_LIMIT = 400;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic             dmem_we;
    logic [`XLEN-1:0] dmem_rdata;

    logic [`XLEN-1:0] imem [MEM_WORDS];
    logic [`XLEN-1:0] dmem [MEM_WORDS];

    // Store trace seen on the bus and the one predicted by each test
    logic [`XLEN-1:0] got_addr [$];
    logic [`XLEN-1:0] got_data [$];
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];

    // Store captured mid-cycle, committed on the next rising edge
    logic             pend_we = 1'b0;
    logic [`XLEN-1:0] pend_addr;
    logic [`XLEN-1:0] pend_data;
    int               load_ptr;
    integer           seed;

    pipe_cpu pipe_cpu_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // Hazard checks run on the testbench clock
    bind hazard_unit pipe_cpu_assert pipe_cpu_assert_inst (
        .clk      (pipe_cpu_tb.clk),
        .rst_n    (pipe_cpu_tb.rst_n),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .stall    (stall),
        .flush    (flush),
        .mem_dest (mem_dest),
        .wb_dest  (wb_dest)
    );

    always #2 clk = ~clk;

    assign imem_data  = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    // Memory-stage outputs are settled at the falling edge
    always @(negedge clk) begin
        pend_we   = dmem_we;
        pend_addr = dmem_addr;
        pend_data = dmem_wdata;
        if (dmem_we) begin
            got_addr.push_back(dmem_addr);
            got_data.push_back(dmem_wdata);
        end
    end

    always @(posedge clk) begin
        if (pend_we) begin
            dmem[pend_addr[7:0]] = pend_data;
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_value(input string what, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        assert (got === exp) else
            stop_run($sformatf("error: %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    // Fill pattern mixes every address bit into the word
    function automatic logic [`XLEN-1:0] fill_word(input int a);
        return 32'h5a00_0000 + 32'(a) * 32'h0001_0101;
    endfunction

    function automatic logic [`XLEN-1:0] r_type(input alu_op_e f, input int rd,
                                                input int rs, input int rt, input int sh);
        return {OP_ALU, rd[4:0], rs[4:0], rt[4:0], sh[4:0], f, 2'b00};
    endfunction

    function automatic logic [`XLEN-1:0] i_type(input opcode_e op, input int rd,
                                                input int rs, input int imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic logic [`XLEN-1:0] j_type(input int tgt);
        return {OP_J, tgt[26:0]};
    endfunction

    task automatic emit(input logic [`XLEN-1:0] word);
        imem[load_ptr[7:0]] = word;
        load_ptr++;
    endtask

    task automatic expect_store(input int addr, input logic [`XLEN-1:0] value);
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    // sw rd, addr(r0) together with its predicted bus write
    task automatic store_reg(input int rd, input int addr, input logic [`XLEN-1:0] value);
        emit(i_type(OP_SW, rd, 0, addr));
        expect_store(addr, value);
    endtask

    task automatic halt();
        emit(j_type(load_ptr));
    endtask

    task automatic clear_memories();
        foreach (imem[i]) begin
            // All-zero word is add r0, r0, r0
            imem[i] = '0;
            dmem[i] = fill_word(i);
        end
    endtask

    // Reset is held while the next program is loaded
    task automatic hold_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("dmem_we in reset", {31'b0, dmem_we}, '0);
            check_value("imem_addr in reset", imem_addr, `RESET_PC);
        end
        got_addr.delete();
        got_data.delete();
        exp_addr.delete();
        exp_data.delete();
        load_ptr = 0;
        clear_memories();
    endtask

    task automatic release_reset();
        rst_n = 1'b1;
        #1;
        check_value("imem_addr after reset", imem_addr, `RESET_PC);
        @(negedge clk);
        check_value("dmem_we after first edge", {31'b0, dmem_we}, '0);
        check_value("imem_addr after first edge", imem_addr, `RESET_PC + 1);
    endtask

    task automatic wait_for_stores(input int count);
        int cycles;
        cycles = 0;
        while (got_addr.size() < count && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (got_addr.size() < count) begin
            stop_run($sformatf("timed out after %0d cycles waiting for %0d stores",
                               cycles, count));
        end
        // Extra cycles expose stores that should never happen
        repeat (8) @(negedge clk);
    endtask

    task automatic compare_stores(input string test);
        assert (got_addr.size() == exp_addr.size()) else
            stop_run($sformatf("error: %0t ns: %s saw %0d stores, expected %0d",
                               $time, test, got_addr.size(), exp_addr.size()));
        foreach (exp_addr[i]) begin
            check_value($sformatf("%s store %0d address", test, i), got_addr[i], exp_addr[i]);
            check_value($sformatf("%s store %0d data", test, i), got_data[i], exp_data[i]);
        end
    endtask

    task automatic run_program(input string test);
        halt();
        release_reset();
        wait_for_stores(exp_addr.size());
        compare_stores(test);
    endtask

    task automatic test_alu_forwarding();
        logic [`XLEN-1:0] r1, r2, r3, r4, r5, r6, r7, r8, r9;
        hold_reset();
        r1 = 32'd25;
        r2 = r1 - 32'd7;
        r3 = r1 + r2;
        r4 = r2 - r3;
        r5 = r4 & r3;
        r6 = r5 | r2;
        r7 = r6 << 3;
        r8 = $signed(r4) >>> 2;
        r9 = r8 + r7 - r1;
        // Each store takes its data from the memory stage, the next op from writeback
        emit(i_type(OP_ADDI, 1, 0, 25));
        store_reg(1, 16, r1);
        emit(i_type(OP_ADDI, 2, 1, -7));
        store_reg(2, 17, r2);
        emit(r_type(ALU_ADD, 3, 1, 2, 0));
        store_reg(3, 18, r3);
        emit(r_type(ALU_SUB, 4, 2, 3, 0));
        store_reg(4, 19, r4);
        emit(r_type(ALU_AND, 5, 4, 3, 0));
        store_reg(5, 20, r5);
        emit(r_type(ALU_OR, 6, 5, 2, 0));
        store_reg(6, 21, r6);
        emit(r_type(ALU_SLL, 7, 6, 0, 3));
        store_reg(7, 22, r7);
        // Negative operand keeps its sign
        emit(r_type(ALU_SRA, 8, 4, 0, 2));
        store_reg(8, 23, r8);
        // Back to back, second op reads the first from the memory stage
        emit(r_type(ALU_ADD, 9, 8, 7, 0));
        emit(r_type(ALU_SUB, 9, 9, 1, 0));
        store_reg(9, 24, r9);
        run_program("alu forwarding");
    endtask

    task automatic test_load_use();
        hold_reset();
        emit(i_type(OP_ADDI, 1, 0, 77));
        emit(i_type(OP_ADDI, 2, 0, 5));
        store_reg(1, 40, 32'd77);
        emit(i_type(OP_LW, 3, 0, 40));
        // Loaded value used by the very next instruction
        emit(r_type(ALU_ADD, 4, 3, 2, 0));
        store_reg(4, 41, 32'd77 + 32'd5);
        // Base register plus offset, 5 + 36
        emit(i_type(OP_LW, 5, 2, 36));
        store_reg(5, 42, 32'd82);
        emit(i_type(OP_LW, 6, 0, 50));
        store_reg(6, 43, fill_word(50));
        run_program("load use");
    endtask

    // Branch or jump to pc + 3 over two stores, then a store at the target
    task automatic branch_block(input opcode_e op, input int ra, input int rb,
                                input logic [`XLEN-1:0] va, input logic [`XLEN-1:0] vb,
                                input int addr);
        logic taken;
        case (op)
            OP_BNE:  taken = (va != vb);
            OP_BLT:  taken = ($signed(va) < $signed(vb));
            default: taken = 1'b1;
        endcase
        if (op == OP_J) begin
            emit(j_type(load_ptr + 3));
        end else begin
            emit(i_type(op, ra, rb, 2));
        end
        if (!taken) begin
            expect_store(addr, va);
            expect_store(addr + 1, va);
        end
        emit(i_type(OP_SW, ra, 0, addr));
        emit(i_type(OP_SW, ra, 0, addr + 1));
        store_reg(rb, addr + 2, vb);
    endtask

    task automatic test_branches();
        logic [`XLEN-1:0] v1, v2, v3;
        hold_reset();
        v1 = 32'd3;
        v2 = -32'sd4;
        v3 = -32'sd9;
        emit(i_type(OP_ADDI, 1, 0, 3));
        emit(i_type(OP_ADDI, 2, 0, -4));
        emit(i_type(OP_ADDI, 3, 0, -9));
        branch_block(OP_BNE, 1, 2, v1, v2, 60);
        branch_block(OP_BNE, 1, 1, v1, v1, 63);
        branch_block(OP_BLT, 2, 1, v2, v1, 66);
        branch_block(OP_BLT, 1, 2, v1, v2, 69);
        // Both operands negative
        branch_block(OP_BLT, 3, 2, v3, v2, 72);
        branch_block(OP_BLT, 2, 3, v2, v3, 75);
        branch_block(OP_J, 1, 2, v1, v2, 78);
        run_program("branches");
    endtask

    task automatic test_random_program();
        logic [`XLEN-1:0] model [`NUM_REGS];
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        int kind, rd, rs, rt, sh, imm;
        hold_reset();
        foreach (model[i]) begin
            model[i] = '0;
        end
        for (int n = 0; n < 40; n++) begin
            kind = $unsigned($random(seed)) % 7;
            rd   = $unsigned($random(seed)) % 8;
            rs   = $unsigned($random(seed)) % 8;
            rt   = $unsigned($random(seed)) % 8;
            sh   = $unsigned($random(seed)) % 32;
            // Stays inside the signed 17-bit immediate range
            imm  = $random(seed) % 65536;
            a    = model[rs[4:0]];
            b    = model[rt[4:0]];
            case (kind)
                0: begin
                    emit(i_type(OP_ADDI, rd, rs, imm));
                    res = a + imm;
                end
                1: begin
                    emit(r_type(ALU_ADD, rd, rs, rt, 0));
                    res = a + b;
                end
                2: begin
                    emit(r_type(ALU_SUB, rd, rs, rt, 0));
                    res = a - b;
                end
                3: begin
                    emit(r_type(ALU_AND, rd, rs, rt, 0));
                    res = a & b;
                end
                4: begin
                    emit(r_type(ALU_OR, rd, rs, rt, 0));
                    res = a | b;
                end
                5: begin
                    emit(r_type(ALU_SLL, rd, rs, 0, sh));
                    res = a << sh[4:0];
                end
                default: begin
                    emit(r_type(ALU_SRA, rd, rs, 0, sh));
                    res = $signed(a) >>> sh[4:0];
                end
            endcase
            // r0 ignores writes
            if (rd != 0) begin
                model[rd[4:0]] = res;
            end
            store_reg(rd, 100 + n, model[rd[4:0]]);
        end
        run_program("random program");
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        seed     = 17;
        load_ptr = 0;
        clear_memories();
        test_alu_forwarding();
        test_load_use();
        test_branches();
        test_random_program();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
